// File: design/chan_pkg.sv
`default_nettype none

package chan_pkg;

  //////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////
  localparam int SAMPLE_W = 12;                    // raw adc sample
  localparam int LANE_W   = 16;                    // sample lane, zero-extended
  localparam int BURST_W  = 128;                   // eight lanes per stored burst
  localparam int WORD_W   = 32;                    // link word, two lanes

  localparam int FILL_NUM_W = 24;                  // fill counter in header word 0

  // pedestal is the mean of 2**PED_SAMPLES_LOG2 samples
  localparam int PED_SAMPLES_LOG2 = 3;

  //////////////////////////////////////////////////
  // header opcodes, top byte of each header word
  //////////////////////////////////////////////////
  typedef enum logic [7:0] {
    OP_FILL_HEADER = 8'hF1,                        // carries the fill number
    OP_PEDESTAL    = 8'hF2                         // carries the measured pedestal
  } opcode_e;

  // readout sequencing, one fill per req/ack cycle
  typedef enum logic [2:0] {
    IDLE,                                          // waiting for rd_req with acq_done
    HDR0,                                          // fill header word
    HDR1,                                          // pedestal word
    DATA,                                          // buffer bursts on the link
    ACK                                            // rd_ack high until rd_req drops
  } rd_state_e;

endpackage

`default_nettype wire

// File: design/master_reset.sv
`timescale 1ns/1ps
`default_nettype none

module master_reset #(
  parameter int LONG_RESET_CYCLES = 16
) (
  input  logic clk125,
  input  logic rst_n,
  input  logic rst_from_master,                    // async line from the master
  output logic cnt_reset,                          // short pulse seen
  output logic full_rst                            // long pulse seen
);

  localparam int CNT_W = $clog2(LONG_RESET_CYCLES + 1);
  localparam logic [CNT_W-1:0] LONG_LIM = CNT_W'(LONG_RESET_CYCLES);

  logic [1:0]       line_sync;                     // two-stage synchronizer
  logic [CNT_W-1:0] high_cnt;                      // cycles the line has been high

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      line_sync <= '0;
      high_cnt  <= '0;
      cnt_reset <= 1'b0;
      full_rst  <= 1'b0;
    end else begin
      line_sync <= {line_sync[0], rst_from_master};
      if (line_sync[1]) begin
        if (high_cnt != LONG_LIM) high_cnt <= high_cnt + 1'b1;   // saturate at the limit
        full_rst  <= (high_cnt == LONG_LIM - 1'b1);               // fires once, on the limit
        cnt_reset <= 1'b0;
      end else begin
        // line dropped before the limit, so it was a short pulse
        cnt_reset <= (high_cnt != '0) && (high_cnt != LONG_LIM);
        full_rst  <= 1'b0;
        high_cnt  <= '0;
      end
    end
  end

  // one pulse per master request, never both kinds
  a_one_kind: assert property (@(posedge clk125) disable iff (!rst_n)
    !(cnt_reset && full_rst));

endmodule

`default_nettype wire

// File: design/self_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module self_trigger #(
  parameter int NUM_BURSTS = 2
) (
  input  logic                          clk125,
  input  logic                          rst_n,
  input  logic                          full_rst,
  input  logic                          enable_triggering,
  input  logic [chan_pkg::SAMPLE_W-1:0] adc_sample,
  input  logic [chan_pkg::SAMPLE_W-1:0] selftrig_threshold,
  input  logic                          buf_free,           // readout released the buffer
  output logic                          acq_trig,
  output logic                          acq_done,
  output logic                          wr_en,
  output logic [chan_pkg::SAMPLE_W-1:0] wr_sample,
  output logic [chan_pkg::SAMPLE_W-1:0] pedestal
);

  localparam int SUM_W   = chan_pkg::SAMPLE_W + chan_pkg::PED_SAMPLES_LOG2;
  localparam int CMP_W   = chan_pkg::SAMPLE_W + 1;            // headroom for ped + thr
  localparam int CAP_LEN = NUM_BURSTS * (chan_pkg::BURST_W / chan_pkg::LANE_W);
  localparam int CAP_W   = $clog2(CAP_LEN + 1);

  typedef enum logic [2:0] {ST_IDLE, ST_AVG, ST_ARMED, ST_CAPTURE, ST_DONE} trig_state_e;

  trig_state_e                         state;
  logic [chan_pkg::PED_SAMPLES_LOG2-1:0] ped_cnt;
  logic [SUM_W-1:0]                    ped_sum, sum_next;
  logic [CAP_W-1:0]                    cap_cnt;
  logic [CMP_W-1:0]                    trig_level;
  logic                                hit;

  assign sum_next   = ped_sum + SUM_W'(adc_sample);
  assign trig_level = {1'b0, pedestal} + {1'b0, selftrig_threshold};
  assign hit        = {1'b0, adc_sample} > trig_level;        // strictly above

  always_ff @(posedge clk125) begin
    if (!rst_n || full_rst) begin
      state    <= ST_IDLE;
      ped_cnt  <= '0;
      cap_cnt  <= '0;
      acq_trig <= 1'b0;
      acq_done <= 1'b0;
      wr_en    <= 1'b0;
    end else begin
      acq_trig  <= 1'b0;                                      // pulses by default
      wr_en     <= 1'b0;
      wr_sample <= adc_sample;                                // written only with wr_en
      case (state)
        ST_IDLE: if (enable_triggering) begin
          ped_sum <= SUM_W'(adc_sample);                      // first pedestal sample
          ped_cnt <= 1'b1;
          state   <= ST_AVG;
        end
        ST_AVG: begin
          ped_sum <= sum_next;
          ped_cnt <= ped_cnt + 1'b1;
          if (!enable_triggering) state <= ST_IDLE;
          else if (&ped_cnt) begin                            // eighth sample
            pedestal <= sum_next[SUM_W-1 -: chan_pkg::SAMPLE_W];  // divide by 8
            state    <= ST_ARMED;
          end
        end
        ST_ARMED: begin
          if (!enable_triggering) state <= ST_IDLE;
          else if (hit) begin
            acq_trig <= 1'b1;
            wr_en    <= 1'b1;                                 // trigger sample is lane 0
            cap_cnt  <= CAP_W'(1);
            state    <= ST_CAPTURE;
          end
        end
        ST_CAPTURE: begin
          wr_en   <= 1'b1;
          cap_cnt <= cap_cnt + 1'b1;
          if (cap_cnt == CAP_W'(CAP_LEN - 1)) state <= ST_DONE;
        end
        ST_DONE: begin
          acq_done <= !buf_free;                              // rises after the last write
          if (buf_free) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // nothing lands in the buffer while a fill waits for readout
  a_no_wr_when_done: assert property (@(posedge clk125) disable iff (!rst_n)
    acq_done |-> !wr_en);

endmodule

`default_nettype wire

// File: design/waveform_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module waveform_buffer #(
  parameter int NUM_BURSTS = 2
) (
  input  logic                          clk125,
  input  logic                          rst_n,
  input  logic                          full_rst,
  input  logic                          wr_en,
  input  logic [chan_pkg::SAMPLE_W-1:0] wr_sample,
  input  logic                          rd_start,           // rewind to burst 0
  input  logic                          rd_next,            // current burst taken
  output logic [chan_pkg::BURST_W-1:0]  rd_data,
  output logic                          rd_valid
);

  localparam int LANES = chan_pkg::BURST_W / chan_pkg::LANE_W;
  localparam int PTR_W = (NUM_BURSTS > 1) ? $clog2(NUM_BURSTS) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(NUM_BURSTS - 1);

  logic [chan_pkg::BURST_W-1:0] mem [NUM_BURSTS];
  logic [chan_pkg::BURST_W-1:0] pack, pack_next;
  logic [$clog2(LANES)-1:0]     lane_cnt;
  logic [PTR_W-1:0]             wr_ptr, rd_ptr;

  // new sample enters the top lane, so sample zero ends up in lane 0
  assign pack_next = {{(chan_pkg::LANE_W - chan_pkg::SAMPLE_W){1'b0}}, wr_sample,
                      pack[chan_pkg::BURST_W-1:chan_pkg::LANE_W]};

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (wr_en) pack <= pack_next;
    if (wr_en && &lane_cnt) mem[wr_ptr] <= pack_next;         // eighth sample closes a burst
  end

  always_ff @(posedge clk125) begin
    if (!rst_n || full_rst) begin
      lane_cnt <= '0;
      wr_ptr   <= '0;
    end else if (wr_en) begin
      lane_cnt <= lane_cnt + 1'b1;
      if (&lane_cnt) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // read side, data one cycle after the request
  //////////////////////////////////////////////////
  always_ff @(posedge clk125) begin
    if (!rst_n || full_rst) begin
      rd_ptr   <= '0;
      rd_valid <= 1'b0;
    end else if (rd_start) begin
      rd_ptr   <= '0;
      rd_data  <= mem[0];
      rd_valid <= 1'b1;
    end else if (rd_next) begin
      if (rd_ptr == LAST_PTR) rd_valid <= 1'b0;               // waveform exhausted
      else begin
        rd_ptr  <= rd_ptr + 1'b1;
        rd_data <= mem[rd_ptr + 1'b1];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/burst_width_converter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_width_converter (
  input  logic                         clk125,
  input  logic                         rst_n,
  input  logic                         full_rst,
  input  logic [chan_pkg::BURST_W-1:0] s_data,
  input  logic                         s_valid,
  input  logic                         s_last,
  output logic                         s_ready,
  output logic [chan_pkg::WORD_W-1:0]  m_data,
  output logic                         m_valid,
  output logic                         m_last,
  input  logic                         m_ready
);

  logic [chan_pkg::BURST_W-1:0] cur, held;      // burst being read, burst waiting
  logic                         cur_valid, held_valid;
  logic                         cur_last, held_last;
  logic [1:0]                   lane;           // word index inside cur
  logic                         word_done, cur_free, accept;

  assign accept    = s_valid && s_ready;
  assign word_done = m_valid && m_ready;
  assign cur_free  = !cur_valid || (word_done && lane == 2'd3);   // empty or emptying

  assign s_ready = !held_valid;                 // room for one more burst
  assign m_valid = cur_valid;
  assign m_data  = cur[lane*chan_pkg::WORD_W +: chan_pkg::WORD_W];  // lowest word first
  assign m_last  = cur_last && lane == 2'd3;

  always_ff @(posedge clk125) begin
    if (!rst_n || full_rst) begin
      cur_valid  <= 1'b0;
      held_valid <= 1'b0;
      lane       <= '0;
    end else begin
      if (word_done) lane <= lane + 1'b1;       // wraps after the fourth word
      if (cur_free) begin
        if (held_valid) begin                   // waiting burst moves up
          cur        <= held;
          cur_last   <= held_last;
          cur_valid  <= 1'b1;
          held_valid <= 1'b0;
        end else begin
          cur       <= s_data;
          cur_last  <= s_last;
          cur_valid <= accept;
        end
      end else if (accept) begin                // cur still busy, park it
        held       <= s_data;
        held_last  <= s_last;
        held_valid <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/readout_control.sv
`timescale 1ns/1ps
`default_nettype none

module readout_control #(
  parameter int NUM_BURSTS = 2
) (
  input  logic                          clk125,
  input  logic                          rst_n,
  input  logic                          full_rst,
  input  logic                          cnt_reset,          // zero the fill number
  input  logic                          acq_done,
  input  logic                          rd_req,
  input  logic [chan_pkg::SAMPLE_W-1:0] pedestal,
  input  logic                          cmd_ready,
  input  logic                          data_accept,        // buffer word taken by the link
  input  logic                          data_last,          // converter last before the accept qualifier
  output logic                          rd_ack,
  output logic                          buf_free,
  output logic                          rd_start,
  output logic                          use_buffer_data,
  output logic [chan_pkg::WORD_W-1:0]   cmd_data,
  output logic                          cmd_valid,
  output logic                          cmd_last,
  output logic                          burst_valid,
  output logic                          burst_last
);

  localparam int SENT_W = $clog2(NUM_BURSTS + 1);
  localparam int PAD_W  = chan_pkg::WORD_W - 8 - chan_pkg::SAMPLE_W;

  chan_pkg::rd_state_e               state;
  logic [chan_pkg::FILL_NUM_W-1:0]   fill_num;
  logic [SENT_W-1:0]                 sent;      // bursts handed to the converter
  logic [1:0]                        occ;       // bursts inside the converter
  logic [1:0]                        word_cnt;  // words of the oldest burst sent
  logic                              drain, fill_done;

  assign drain     = data_accept && word_cnt == 2'd3;
  assign fill_done = data_accept && data_last;

  assign rd_start        = state == chan_pkg::IDLE && rd_req && acq_done;
  assign rd_ack          = state == chan_pkg::ACK;
  assign use_buffer_data = state == chan_pkg::DATA;
  assign cmd_valid       = state == chan_pkg::HDR0 || state == chan_pkg::HDR1;
  assign cmd_last        = 1'b0;                // headers never close a fill
  assign cmd_data = (state == chan_pkg::HDR0) ?
                    {chan_pkg::OP_FILL_HEADER, fill_num} :
                    {chan_pkg::OP_PEDESTAL, {PAD_W{1'b0}}, pedestal};

  // offer a burst only when the converter has a free slot
  assign burst_valid = use_buffer_data && sent != SENT_W'(NUM_BURSTS) && occ != 2'd2;
  assign burst_last  = sent == SENT_W'(NUM_BURSTS - 1);

  always_ff @(posedge clk125) begin
    if (!rst_n || full_rst) begin
      state    <= chan_pkg::IDLE;
      fill_num <= '0;
      sent     <= '0;
      occ      <= '0;
      word_cnt <= '0;
      buf_free <= 1'b0;
    end else begin
      buf_free <= 1'b0;
      occ      <= occ + {1'b0, burst_valid} - {1'b0, drain};
      if (data_accept) word_cnt <= word_cnt + 1'b1;
      if (burst_valid) sent <= sent + 1'b1;
      case (state)
        chan_pkg::IDLE: if (rd_start) begin
          sent  <= '0;
          state <= chan_pkg::HDR0;
        end
        chan_pkg::HDR0: if (cmd_ready) state <= chan_pkg::HDR1;
        chan_pkg::HDR1: if (cmd_ready) state <= chan_pkg::DATA;
        chan_pkg::DATA: if (fill_done) begin
          fill_num <= fill_num + 1'b1;
          buf_free <= 1'b1;                     // self_trigger may rearm
          state    <= chan_pkg::ACK;
        end
        chan_pkg::ACK: if (!rd_req) state <= chan_pkg::IDLE;   // four-phase close
        default: state <= chan_pkg::IDLE;
      endcase
      if (cnt_reset) fill_num <= '0;            // master wins over the increment
    end
  end

  // at ack the mux is back on commands and no burst is left in the converter
  a_ack_drained: assert property (@(posedge clk125) disable iff (!rst_n)
    rd_ack |-> !use_buffer_data && occ == 2'd0);

endmodule

`default_nettype wire

// File: design/link_tx_mux.sv
`timescale 1ns/1ps
`default_nettype none

module link_tx_mux (
  input  logic        clk125,
  input  logic        rst_n,
  input  logic        readout_pause,            // async from the master
  input  logic        use_buffer_data,
  input  logic [31:0] cmd_data,
  input  logic        cmd_valid,
  input  logic        cmd_last,
  output logic        cmd_ready,
  input  logic [31:0] data_data,
  input  logic        data_valid,
  input  logic        data_last,
  output logic        data_ready,
  output logic [31:0] tx_tdata,
  output logic        tx_tvalid,
  output logic        tx_tlast,
  input  logic        tx_tready,
  output logic        data_accept
);

  logic [1:0] pause_sync;
  logic       link_go;                          // link ready and not paused

  always_ff @(posedge clk125) begin
    if (!rst_n) pause_sync <= '0;
    else        pause_sync <= {pause_sync[0], readout_pause};
  end

  assign link_go = tx_tready && !pause_sync[1];

  // 2:1 select, pause also hides valid from the link
  assign tx_tdata  = use_buffer_data ? data_data : cmd_data;
  assign tx_tlast  = use_buffer_data ? data_last : cmd_last;
  assign tx_tvalid = (use_buffer_data ? data_valid : cmd_valid) && !pause_sync[1];

  assign data_ready  = use_buffer_data && link_go;   // only the chosen source sees ready
  assign cmd_ready   = !use_buffer_data && link_go;
  assign data_accept = data_ready && data_valid;

endmodule

`default_nettype wire

// File: design/channel_selftrig_top.sv
`timescale 1ns/1ps
`default_nettype none

module channel_selftrig_top #(
  parameter int NUM_BURSTS        = 2,
  parameter int LONG_RESET_CYCLES = 16
) (
  input  logic                          clk125,
  input  logic                          rst_n,
  input  logic [chan_pkg::SAMPLE_W-1:0] adc_sample,
  input  logic                          enable_triggering,
  input  logic [chan_pkg::SAMPLE_W-1:0] selftrig_threshold,
  input  logic                          rst_from_master,
  input  logic                          readout_pause,
  input  logic                          rd_req,
  input  logic                          tx_tready,
  output logic                          acq_trig,
  output logic                          acq_done,
  output logic                          rd_ack,
  output logic [chan_pkg::WORD_W-1:0]   tx_tdata,
  output logic                          tx_tvalid,
  output logic                          tx_tlast
);

  logic                          cnt_reset, full_rst, buf_free;
  logic                          wr_en;
  logic [chan_pkg::SAMPLE_W-1:0] wr_sample, pedestal;
  logic                          rd_start, rd_valid;
  logic [chan_pkg::BURST_W-1:0]  rd_data;
  logic                          burst_valid, burst_last, burst_ready;
  logic [chan_pkg::WORD_W-1:0]   word_data, cmd_data;
  logic                          word_valid, word_last, word_ready;
  logic                          cmd_valid, cmd_last, cmd_ready;
  logic                          use_buffer_data, data_accept;

  master_reset #(.LONG_RESET_CYCLES(LONG_RESET_CYCLES)) master_reset_inst (
    .clk125, .rst_n, .rst_from_master, .cnt_reset, .full_rst
  );

  self_trigger #(.NUM_BURSTS(NUM_BURSTS)) self_trigger_inst (
    .clk125, .rst_n, .full_rst, .enable_triggering, .adc_sample, .selftrig_threshold,
    .buf_free, .acq_trig, .acq_done, .wr_en, .wr_sample, .pedestal
  );

  waveform_buffer #(.NUM_BURSTS(NUM_BURSTS)) waveform_buffer_inst (
    .clk125, .rst_n, .full_rst, .wr_en, .wr_sample, .rd_start,
    .rd_next (burst_valid),                     // each offered burst is taken
    .rd_data, .rd_valid
  );

  burst_width_converter burst_width_converter_inst (
    .clk125, .rst_n, .full_rst,
    .s_data  (rd_data),     .s_valid (burst_valid), .s_last (burst_last),
    .s_ready (burst_ready),
    .m_data  (word_data),   .m_valid (word_valid),  .m_last (word_last),
    .m_ready (word_ready)
  );

  readout_control #(.NUM_BURSTS(NUM_BURSTS)) readout_control_inst (
    .clk125, .rst_n, .full_rst, .cnt_reset, .acq_done, .rd_req, .pedestal,
    .cmd_ready, .data_accept,
    .data_last (word_last),
    .rd_ack, .buf_free, .rd_start, .use_buffer_data,
    .cmd_data, .cmd_valid, .cmd_last, .burst_valid, .burst_last
  );

  link_tx_mux link_tx_mux_inst (
    .clk125, .rst_n, .readout_pause, .use_buffer_data,
    .cmd_data, .cmd_valid, .cmd_last, .cmd_ready,
    .data_data (word_data), .data_valid (word_valid), .data_last (word_last),
    .data_ready (word_ready),
    .tx_tdata, .tx_tvalid, .tx_tlast, .tx_tready, .data_accept
  );

  // the occupancy count in readout_control must match the converter and buffer
  a_burst_offer_ok: assert property (@(posedge clk125) disable iff (!rst_n)
    burst_valid |-> burst_ready && rd_valid);

endmodule

`default_nettype wire

// File: dv/channel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module channel_tb;

  localparam int MAX_TESTS = 16;
  localparam int NUM_WORDS = 10;                   // two headers and eight data words

  logic                          clk125, rst_n;
  logic [chan_pkg::SAMPLE_W-1:0] adc_sample, selftrig_threshold;
  logic                          enable_triggering, rst_from_master, readout_pause;
  logic                          rd_req, tx_tready, acq_trig, acq_done, rd_ack;
  logic [chan_pkg::WORD_W-1:0]   tx_tdata;
  logic                          tx_tvalid, tx_tlast;

  // test table with one entry per data file line
  string       names [MAX_TESTS];
  string       rst_kind [MAX_TESTS];
  logic [11:0] thr [MAX_TESTS];
  logic [11:0] exp_ped [MAX_TESTS];
  logic [23:0] exp_fill [MAX_TESTS];
  logic [11:0] ped_s [MAX_TESTS][8];
  logic [11:0] cap_s [MAX_TESTS][16];
  logic        pause_en [MAX_TESTS];
  logic        rand_rdy [MAX_TESTS];
  int          num_tests;

  logic [31:0] exp_words [NUM_WORDS];
  logic [31:0] got_words [$];                      // words accepted by the link
  logic        got_last [$];
  logic [31:0] lfsr = 32'h2f0f_991a;
  string       cur_name = "setup";
  int          trig_cnt, pause_run, cycle_cnt, cycle_limit;

  channel_selftrig_top #(.NUM_BURSTS(2), .LONG_RESET_CYCLES(16)) channel_selftrig_top_inst (
    .clk125, .rst_n, .adc_sample, .enable_triggering, .selftrig_threshold, .rst_from_master,
    .readout_pause, .rd_req, .tx_tready, .acq_trig, .acq_done, .rd_ack,
    .tx_tdata, .tx_tvalid, .tx_tlast
  );

  initial begin
    clk125 = 1'b0;
    forever #10 clk125 = ~clk125;                  // 20 ns period
  end

  //////////////////////////////////////////////////
  // error handling
  //////////////////////////////////////////////////
  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("Error: test %s, %s expected %h actual %h", cur_name, what, exp, act);
    abort_run();
  endtask

  task automatic report_failure(input string msg);
    $display("test %s: %s", cur_name, msg);
    abort_run();
  endtask

  // x^32 + x^22 + x^2 + x + 1 with the feedback entering bit 0
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_cycle();                     // move to the drive point 2 ns after the edge
    @(posedge clk125);
    #2;
  endtask

  task automatic load_tests();
    int               fd, n;
    string            tok;
    logic [8*256-1:0] skip;
    fd = $fopen("dv/channel_tests.txt", "r");
    assert (fd != 0) else report_failure("cannot open dv/channel_tests.txt");
    num_tests = 0;
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok[0] == "#") begin
        n = $fgets(skip, fd);                      // drop the rest of a comment line
      end else begin
        names[num_tests] = tok;
        n = $fscanf(fd, "%h %s %h %h", thr[num_tests], rst_kind[num_tests],
                    pause_en[num_tests], rand_rdy[num_tests]);
        for (int k = 0; k < 8; k++) n = $fscanf(fd, "%h", ped_s[num_tests][k]);
        for (int k = 0; k < 16; k++) n = $fscanf(fd, "%h", cap_s[num_tests][k]);
        n = $fscanf(fd, "%h %h", exp_ped[num_tests], exp_fill[num_tests]);
        assert (n == 2) else report_failure("truncated line in dv/channel_tests.txt");
        num_tests++;
      end
    end
    $fclose(fd);
  endtask

  // expected fill words of test t from the trigger rule
  task automatic build_expected(input int t);
    int          level;
    logic [11:0] lane [16];
    int          first;
    level = int'(exp_ped[t]) + int'(thr[t]);
    first = -1;
    for (int k = 15; k >= 0; k--) begin
      if (int'(cap_s[t][k]) > level) first = k;    // strictly above ped + thr
    end
    assert (first >= 0) else report_failure("no capture sample above pedestal plus threshold");
    for (int k = 0; k < 16; k++) lane[k] = (first + k < 16) ? cap_s[t][first + k] : 12'h000;
    exp_words[0] = {8'hF1, exp_fill[t]};
    exp_words[1] = {8'hF2, 12'h000, exp_ped[t]};
    for (int j = 0; j < 8; j++) exp_words[2 + j] = {4'h0, lane[2*j+1], 4'h0, lane[2*j]};
  endtask

  task automatic master_pulse(input int len);
    rst_from_master = 1'b1;
    repeat (len) next_cycle();
    rst_from_master = 1'b0;
    repeat (6) next_cycle();                       // sync plus classification
  endtask

  task automatic run_capture(input int t);
    trig_cnt = 0;
    for (int k = 0; k < 40; k++) begin             // pedestal then listed samples then zero tail
      enable_triggering = 1'b1;
      adc_sample = (k < 8) ? ped_s[t][k] : (k < 24) ? cap_s[t][k - 8] : 12'h000;
      next_cycle();
    end
    enable_triggering = 1'b0;
    while (!acq_done) next_cycle();
    assert (trig_cnt == 1) else report_mismatch("acq_trig pulses", 1, trig_cnt);
  endtask

  task automatic read_fill(input int t);
    int cyc;
    got_words.delete();
    got_last.delete();
    cyc = 0;
    rd_req = 1'b1;
    while (!rd_ack) begin
      next_cycle();
      if (rand_rdy[t]) begin
        lfsr      = lfsr_step(lfsr);               // one step per ready bit taken
        tx_tready = lfsr[0];
      end else begin
        tx_tready = 1'b1;
      end
      readout_pause = pause_en[t] && cyc >= 6 && cyc < 12;   // mid-stream pause
      cyc++;
    end
    tx_tready = 1'b1;
    readout_pause = 1'b0;
    assert (got_words.size() == NUM_WORDS)
      else report_mismatch("words before rd_ack", NUM_WORDS, got_words.size());
    for (int i = 0; i < NUM_WORDS; i++) begin
      assert (got_words[i] === exp_words[i])
        else report_mismatch($sformatf("word %0d", i), exp_words[i], got_words[i]);
      assert (got_last[i] === (i == NUM_WORDS - 1))
        else report_mismatch($sformatf("tlast of word %0d", i), i == NUM_WORDS - 1, got_last[i]);
    end
    repeat (3) begin
      next_cycle();
      assert (rd_ack) else report_failure("rd_ack dropped while rd_req was still high");
    end
    rd_req = 1'b0;
    while (rd_ack) next_cycle();
    assert (!acq_done) else report_failure("acq_done still high after the fill was read");
  endtask

  task automatic run_test(input int t);
    cur_name = names[t];
    selftrig_threshold = thr[t];
    build_expected(t);
    if (rst_kind[t] == "short") master_pulse(4);
    else if (rst_kind[t] == "long") begin
      run_capture(t);                              // leave a fill pending
      master_pulse(20);
      assert (!acq_done) else report_failure("long master reset left acq_done high");
    end
    run_capture(t);
    read_fill(t);
  endtask

  //////////////////////////////////////////////////
  // monitors on the falling edge
  //////////////////////////////////////////////////
  always @(negedge clk125) begin
    if (tx_tvalid && tx_tready) begin
      got_words.push_back(tx_tdata);
      got_last.push_back(tx_tlast);
    end
    if (acq_trig) begin
      trig_cnt++;
      assert (!acq_done) else report_failure("acq_trig while acq_done was high");
    end
    pause_run = readout_pause ? pause_run + 1 : 0;
    // pause held over two rising edges has reached the link
    assert (!(pause_run > 2 && tx_tvalid)) else report_failure("tx_tvalid high during pause");
  end

  always @(posedge clk125) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, DUT stopped responding", cycle_limit);
      abort_run();
    end
  end

  initial begin
    rst_n = 1'b0;
    adc_sample = '0;
    selftrig_threshold = '0;
    enable_triggering = 1'b0;
    rst_from_master = 1'b0;
    readout_pause = 1'b0;
    rd_req = 1'b0;
    tx_tready = 1'b1;
    load_tests();
    cycle_limit = 200 * num_tests + 100;
    repeat (8) @(posedge clk125);
    #2 rst_n = 1'b1;
    for (int t = 0; t < num_tests; t++) run_test(t);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
design/chan_pkg.sv
design/master_reset.sv
design/self_trigger.sv
design/waveform_buffer.sv
design/burst_width_converter.sv
design/readout_control.sv
design/link_tx_mux.sv
design/channel_selftrig_top.sv
dv/channel_tb.sv

// File: dv/channel_tests.txt
# name thr reset pause rand ped0..ped7 cap0..cap15 exp_ped exp_fill
# all values hex, reset is none, short or long and is applied before the test
t_basic 040 none 0 0 100 102 0FE 101 0FF 100 103 0FD 200 2A0 3F0 350 2C0 230 1C0 160 130 120 118 110 108 104 102 101 100 0
t_strict 020 none 0 0 080 080 080 080 080 080 080 080 090 0A0 0A1 0B5 0F0 150 1A0 1E0 1B0 170 140 110 0F0 0C0 0A0 090 080 1
t_backpr 040 none 0 1 100 102 0FE 101 0FF 100 103 0FD 200 2A0 3F0 350 2C0 230 1C0 160 130 120 118 110 108 104 102 101 100 2
t_pause 010 none 1 1 7F0 7F1 7F2 7F3 7F4 7F5 7F6 7F7 800 803 804 900 A00 B00 C00 D00 E00 FFF F00 E00 D00 C00 B00 A00 7F3 3
t_short 100 short 0 0 000 001 002 003 004 005 006 007 050 103 104 2AB 3CD 4EF 501 623 745 867 989 AAB BCD CEF D01 E23 003 0
t_after_sh 050 none 1 0 200 200 200 200 200 200 200 200 251 260 270 280 290 2A0 2B0 2C0 2D0 2E0 2F0 300 310 320 330 340 200 1
t_long 030 long 0 0 400 408 410 418 3F8 3F0 3E8 3E0 42C 42D 480 4C0 500 540 580 5C0 600 640 680 6C0 700 740 780 7C0 3FC 0
t_after_lg 000 none 1 1 010 010 010 010 010 010 010 010 010 010 011 ABC 123 456 789 FED 0CB A98 765 432 1FF 2EE 3DD 4CC 010 1
